//--- verilog/gfx_fixed_pkg.sv
// all arithmetic wraps silently, there is no saturation on any of these types
package gfx_fixed_pkg;

	typedef logic signed [15:0] q8_8_t;   // world, matrix and clip values
	typedef logic signed [15:0] q2_14_t;  // normalized device coords
	typedef logic signed [19:0] int20_t;  // screen coords and edge values

	localparam q8_8_t Q_ONE = 16'sh0100;  // homogeneous w of world vertices
	localparam int NDC_FRAC = 14;

	typedef struct packed {
		q8_8_t x;
		q8_8_t y;
		q8_8_t z;
	} world_vtx_t;

	typedef struct packed {world_vtx_t v0; world_vtx_t v1; world_vtx_t v2;} world_tri_t;

	typedef struct packed {q8_8_t m0; q8_8_t m1; q8_8_t m2; q8_8_t m3;} mat_row_t;

	// z row is not carried, depth is never used downstream
	typedef struct packed {mat_row_t x; mat_row_t y; mat_row_t w;} vp_matrix_t;

	typedef struct packed {int20_t x; int20_t y;} screen_vtx_t;

	typedef struct packed {screen_vtx_t v0; screen_vtx_t v1; screen_vtx_t v2;} screen_tri_t;

	typedef struct packed {int20_t e0; int20_t e1; int20_t e2;} edge_init_t;

endpackage

//--- verilog/raster_timing_pkg.sv
// active area must fit the 10-bit counter, blanking lengths are left to the display timing
package raster_timing_pkg;

	typedef logic [9:0] coord_t;  // display counter x or y

	// visible area of the default 640x480 mode
	localparam int DEF_H_ACTIVE = 640;
	localparam int DEF_V_ACTIVE = 480;

endpackage

//--- verilog/persp_divide.sv
// one divide at a time, i_req is ignored until o_done; a zero divisor returns zero
`timescale 1ns/1ps

module persp_divide (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   i_req,
	input  logic signed [31:0]     i_num,
	input  logic signed [31:0]     i_den,
	output logic                   o_done,
	output gfx_fixed_pkg::q2_14_t  o_quot
);

	typedef enum logic [1:0] {D_IDLE, D_RUN, D_SIGN} state_t;

	state_t state;
	logic [4:0] bit_cnt;
	logic [31:0] quo;      // dividend shifts out, quotient shifts in
	logic [32:0] rem;
	logic [31:0] den_mag;
	logic neg;
	logic den_zero;
	logic [32:0] rem_sh;
	logic signed [31:0] quo_s;

	assign rem_sh = {rem[31:0], quo[31]};
	assign quo_s = neg ? -$signed(quo) : $signed(quo);  // truncates toward zero

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= D_IDLE;
			bit_cnt <= '0;
			o_done <= 1'b0;
		end else begin
			o_done <= 1'b0;
			case (state)
				D_IDLE: begin
					bit_cnt <= '0;
					if (i_req)
						state <= D_RUN;
				end
				D_RUN: begin
					bit_cnt <= bit_cnt + 5'd1;
					if (bit_cnt == 5'd31)
						state <= D_SIGN;
				end
				D_SIGN: begin
					o_done <= 1'b1;
					state <= D_IDLE;
				end
				default: state <= D_IDLE;
			endcase
		end
	end

	// restoring steps on magnitudes, one quotient bit per clock
	always_ff @(posedge clk) begin
		if ((state == D_IDLE) && i_req) begin
			quo <= i_num[31] ? -i_num : i_num;
			den_mag <= i_den[31] ? -i_den : i_den;
			rem <= '0;
			neg <= i_num[31] ^ i_den[31];
			den_zero <= (i_den == 32'sd0);
		end else if (state == D_RUN) begin
			if (rem_sh >= {1'b0, den_mag}) begin
				rem <= rem_sh - {1'b0, den_mag};
				quo <= {quo[30:0], 1'b1};
			end else begin
				rem <= rem_sh;
				quo <= {quo[30:0], 1'b0};
			end
		end
		if (state == D_SIGN)
			o_quot <= den_zero ? '0 : quo_s[15:0];  // low 16 bits kept
	end

endmodule

//--- verilog/clip_transform.sv
// strobes during o_busy are dropped; a zero clip w puts that vertex at the screen centre
`timescale 1ns/1ps

module clip_transform #(
	parameter int H_ACTIVE = 640,
	parameter int V_ACTIVE = 480
) (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        i_tri_valid,
	input  gfx_fixed_pkg::world_tri_t   i_tri,
	input  gfx_fixed_pkg::vp_matrix_t   i_vp,
	output logic                        o_busy,
	output logic                        o_new_tri,
	output gfx_fixed_pkg::screen_tri_t  o_screen_tri
);

	typedef enum logic [2:0] {S_IDLE, S_ROW_MAC, S_DIVIDE, S_MAP, S_WRITE} state_t;

	localparam int H_HALF = H_ACTIVE / 2;
	localparam int V_HALF = V_ACTIVE / 2;

	state_t state;
	logic [1:0] vtx_cnt;
	logic [1:0] row_cnt;   // 0 x, 1 y, 2 w
	logic [1:0] term_cnt;
	logic [2:0] div_cnt;   // x0 y0 x1 y1 x2 y2
	logic div_pend;
	logic signed [31:0] acc;
	gfx_fixed_pkg::q8_8_t clip_val [3][3];  // [vertex][row]
	gfx_fixed_pkg::q2_14_t ndc_val [6];
	gfx_fixed_pkg::screen_tri_t scr_tri;
	gfx_fixed_pkg::world_vtx_t cur_vtx;
	gfx_fixed_pkg::mat_row_t cur_row;
	gfx_fixed_pkg::q8_8_t mac_a;
	gfx_fixed_pkg::q8_8_t mac_b;
	logic signed [31:0] mac_prod;
	logic signed [31:0] mac_sum;
	logic signed [31:0] mac_shift;
	gfx_fixed_pkg::q8_8_t num_src;
	gfx_fixed_pkg::q8_8_t den_src;
	logic div_req;
	logic signed [31:0] div_num;
	logic signed [31:0] div_den;
	logic div_done;
	gfx_fixed_pkg::q2_14_t div_quot;

	// half + ndc * half, ndc in Q2.14
	function automatic gfx_fixed_pkg::int20_t map_coord(gfx_fixed_pkg::q2_14_t ndc, int half);
		logic signed [31:0] half_s;
		logic signed [31:0] prod;
		half_s = half;
		prod = ndc * half_s;
		return gfx_fixed_pkg::int20_t'(half_s + (prod >>> gfx_fixed_pkg::NDC_FRAC));
	endfunction

	persp_divide u_persp_divide (
		.clk    (clk),
		.reset  (reset),
		.i_req  (div_req),
		.i_num  (div_num),
		.i_den  (div_den),
		.o_done (div_done),
		.o_quot (div_quot)
	);

	//////////////////////////////////////////////////
	// row products, one multiply-accumulate per clock
	//////////////////////////////////////////////////
	always_comb begin
		case (vtx_cnt)
			2'd0: cur_vtx = i_tri.v0;
			2'd1: cur_vtx = i_tri.v1;
			default: cur_vtx = i_tri.v2;
		endcase
		case (row_cnt)
			2'd0: cur_row = i_vp.x;
			2'd1: cur_row = i_vp.y;
			default: cur_row = i_vp.w;
		endcase
		case (term_cnt)
			2'd0: begin
				mac_a = cur_vtx.x;
				mac_b = cur_row.m0;
			end
			2'd1: begin
				mac_a = cur_vtx.y;
				mac_b = cur_row.m1;
			end
			2'd2: begin
				mac_a = cur_vtx.z;
				mac_b = cur_row.m2;
			end
			default: begin
				mac_a = gfx_fixed_pkg::Q_ONE;  // w = 1.0
				mac_b = cur_row.m3;
			end
		endcase
	end

	assign mac_prod = mac_a * mac_b;  // Q16.16
	assign mac_sum = (term_cnt == 2'd0) ? mac_prod : acc + mac_prod;
	assign mac_shift = mac_sum >>> 8;  // back to Q8.8

	// divide operands, dividend becomes Q.14 so the quotient lands in Q2.14
	assign num_src = clip_val[div_cnt[2:1]][{1'b0, div_cnt[0]}];
	assign den_src = clip_val[div_cnt[2:1]][2];
	assign div_num = {{16{num_src[15]}}, num_src} << gfx_fixed_pkg::NDC_FRAC;
	assign div_den = {{16{den_src[15]}}, den_src};
	assign div_req = (state == S_DIVIDE) && !div_pend;

	assign o_busy = (state != S_IDLE);
	assign o_new_tri = (state == S_WRITE);
	assign o_screen_tri = scr_tri;

	//////////////////////////////////////////////////
	// sequencing
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_IDLE;
			vtx_cnt <= '0;
			row_cnt <= '0;
			term_cnt <= '0;
			div_cnt <= '0;
			div_pend <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					vtx_cnt <= '0;
					row_cnt <= '0;
					term_cnt <= '0;
					div_cnt <= '0;
					if (i_tri_valid)
						state <= S_ROW_MAC;
				end
				S_ROW_MAC: begin
					term_cnt <= term_cnt + 2'd1;  // wraps after m3
					if (term_cnt == 2'd3) begin
						row_cnt <= (row_cnt == 2'd2) ? 2'd0 : row_cnt + 2'd1;
						if (row_cnt == 2'd2) begin
							vtx_cnt <= vtx_cnt + 2'd1;
							if (vtx_cnt == 2'd2)
								state <= S_DIVIDE;
						end
					end
				end
				S_DIVIDE: begin
					if (div_req)
						div_pend <= 1'b1;
					if (div_done) begin
						div_pend <= 1'b0;
						div_cnt <= div_cnt + 3'd1;
						if (div_cnt == 3'd5)
							state <= S_MAP;
					end
				end
				S_MAP: state <= S_WRITE;
				S_WRITE: state <= S_IDLE;  // buffer loads on this edge
				default: state <= S_IDLE;
			endcase
		end
	end

	// datapath registers
	always_ff @(posedge clk) begin
		if (state == S_ROW_MAC) begin
			acc <= mac_sum;
			if (term_cnt == 2'd3)
				clip_val[vtx_cnt][row_cnt] <= mac_shift[15:0];
		end
		if ((state == S_DIVIDE) && div_done)
			ndc_val[div_cnt] <= div_quot;
		if (state == S_MAP) begin
			scr_tri.v0.x <= map_coord(ndc_val[0], H_HALF);
			scr_tri.v0.y <= map_coord(ndc_val[1], V_HALF);  // no y flip
			scr_tri.v1.x <= map_coord(ndc_val[2], H_HALF);
			scr_tri.v1.y <= map_coord(ndc_val[3], V_HALF);
			scr_tri.v2.x <= map_coord(ndc_val[4], H_HALF);
			scr_tri.v2.y <= map_coord(ndc_val[5], V_HALF);
		end
	end

endmodule

//--- verilog/screen_buffer.sv
// the last finished triangle wins, one landing between two blanks replaces the earlier one
`timescale 1ns/1ps

module screen_buffer #(
	parameter int V_ACTIVE = 480
) (
	input  logic                        clk,
	input  logic                        reset,
	input  raster_timing_pkg::coord_t   i_x,
	input  raster_timing_pkg::coord_t   i_y,
	input  logic                        i_new_tri,
	input  gfx_fixed_pkg::screen_tri_t  i_screen_tri,
	output gfx_fixed_pkg::screen_tri_t  o_disp_tri
);

	gfx_fixed_pkg::screen_tri_t pend_tri;  // written by the transform
	logic swap_evt;

	// first clock of vertical blank
	assign swap_evt = (i_y == V_ACTIVE) && (i_x == '0);

	always_ff @(posedge clk) begin
		if (reset) begin
			pend_tri <= '0;
			o_disp_tri <= '0;
		end else begin
			if (i_new_tri)
				pend_tri <= i_screen_tri;
			// raster never sees a change mid-frame
			if (swap_evt)
				o_disp_tri <= pend_tri;
		end
	end

endmodule

//--- verilog/edge_setup.sv
// edge values are kept in 20 bits and wrap, large triangles need the whole span inside that range
`timescale 1ns/1ps

module edge_setup #(
	parameter int H_ACTIVE = 640,
	parameter int V_ACTIVE = 480
) (
	input  logic                        clk,
	input  logic                        reset,
	input  raster_timing_pkg::coord_t   i_x,
	input  raster_timing_pkg::coord_t   i_y,
	input  gfx_fixed_pkg::screen_tri_t  i_disp_tri,
	output gfx_fixed_pkg::edge_init_t   o_edge_init
);

	typedef enum logic [1:0] {E_IDLE, E_EDGE0, E_EDGE1, E_EDGE2} state_t;

	state_t state;
	logic frame_evt;
	logic line_evt;
	gfx_fixed_pkg::screen_vtx_t vk;   // vertex k
	gfx_fixed_pkg::screen_vtx_t vk1;  // vertex k+1 mod 3
	gfx_fixed_pkg::int20_t dy;
	gfx_fixed_pkg::int20_t dx;
	gfx_fixed_pkg::int20_t prod_x;
	gfx_fixed_pkg::int20_t prod_y;
	gfx_fixed_pkg::int20_t edge_val;
	gfx_fixed_pkg::int20_t b0;
	gfx_fixed_pkg::int20_t b1;
	gfx_fixed_pkg::int20_t b2;

	assign frame_evt = (i_y == V_ACTIVE) && (i_x == 10'd1);  // one after the swap
	assign line_evt = (i_y < V_ACTIVE) && (i_x == H_ACTIVE);

	//////////////////////////////////////////////////
	// edge k = x_k*(y_k - y_k1) + y_k*(x_k1 - x_k)
	//////////////////////////////////////////////////
	always_comb begin
		case (state)
			E_EDGE1: begin
				vk = i_disp_tri.v1;
				vk1 = i_disp_tri.v2;
			end
			E_EDGE2: begin
				vk = i_disp_tri.v2;
				vk1 = i_disp_tri.v0;
			end
			default: begin
				vk = i_disp_tri.v0;
				vk1 = i_disp_tri.v1;
			end
		endcase
	end

	assign dy = vk.y - vk1.y;
	assign dx = vk1.x - vk.x;
	assign prod_x = vk.x * dy;  // low 20 bits only
	assign prod_y = vk.y * dx;
	assign edge_val = prod_x + prod_y;

	// x span of each edge, stepped once per line
	assign b0 = i_disp_tri.v1.x - i_disp_tri.v0.x;
	assign b1 = i_disp_tri.v2.x - i_disp_tri.v1.x;
	assign b2 = i_disp_tri.v0.x - i_disp_tri.v2.x;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= E_IDLE;
			o_edge_init <= '0;
		end else begin
			if (line_evt) begin
				o_edge_init.e0 <= o_edge_init.e0 - b0;
				o_edge_init.e1 <= o_edge_init.e1 - b1;
				o_edge_init.e2 <= o_edge_init.e2 - b2;
			end
			case (state)
				E_IDLE: if (frame_evt) state <= E_EDGE0;
				E_EDGE0: begin
					o_edge_init.e0 <= edge_val;
					state <= E_EDGE1;
				end
				E_EDGE1: begin
					o_edge_init.e1 <= edge_val;
					state <= E_EDGE2;
				end
				E_EDGE2: begin
					o_edge_init.e2 <= edge_val;  // all three valid next clock
					state <= E_IDLE;
				end
				default: state <= E_IDLE;
			endcase
		end
	end

endmodule

//--- verilog/vertex_shader_top.sv
// i_tri and i_vp must be held while o_busy is high, i_x and i_y come from a running display counter
`timescale 1ns/1ps

module vertex_shader_top #(
	parameter int H_ACTIVE = raster_timing_pkg::DEF_H_ACTIVE,
	parameter int V_ACTIVE = raster_timing_pkg::DEF_V_ACTIVE
) (
	input  logic                        clk,
	input  logic                        reset,
	input  raster_timing_pkg::coord_t   i_x,
	input  raster_timing_pkg::coord_t   i_y,
	input  logic                        i_tri_valid,   // one clock strobe
	input  gfx_fixed_pkg::world_tri_t   i_tri,
	input  gfx_fixed_pkg::vp_matrix_t   i_vp,
	output logic                        o_busy,
	output gfx_fixed_pkg::screen_tri_t  o_screen_tri,  // displayed triangle
	output gfx_fixed_pkg::edge_init_t   o_edge_init
);

	logic new_tri;
	gfx_fixed_pkg::screen_tri_t new_screen_tri;

	clip_transform #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)) u_clip_transform (
		.clk          (clk),
		.reset        (reset),
		.i_tri_valid  (i_tri_valid),
		.i_tri        (i_tri),
		.i_vp         (i_vp),
		.o_busy       (o_busy),
		.o_new_tri    (new_tri),
		.o_screen_tri (new_screen_tri)
	);

	screen_buffer #(.V_ACTIVE(V_ACTIVE)) u_screen_buffer (
		.clk          (clk),
		.reset        (reset),
		.i_x          (i_x),
		.i_y          (i_y),
		.i_new_tri    (new_tri),
		.i_screen_tri (new_screen_tri),
		.o_disp_tri   (o_screen_tri)
	);

	edge_setup #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)) u_edge_setup (
		.clk         (clk),
		.reset       (reset),
		.i_x         (i_x),
		.i_y         (i_y),
		.i_disp_tri  (o_screen_tri),
		.o_edge_init (o_edge_init)
	);

endmodule

//--- testbench/tb_tasks.svh
// included inside the testbench module, every task starts and ends on a falling edge
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

	task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else report_fail($sformatf("ERROR %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_screen(input gfx_fixed_pkg::screen_tri_t exp);
		check_hex("o_screen_tri.v0.x", o_screen_tri.v0.x, exp.v0.x);
		check_hex("o_screen_tri.v0.y", o_screen_tri.v0.y, exp.v0.y);
		check_hex("o_screen_tri.v1.x", o_screen_tri.v1.x, exp.v1.x);
		check_hex("o_screen_tri.v1.y", o_screen_tri.v1.y, exp.v1.y);
		check_hex("o_screen_tri.v2.x", o_screen_tri.v2.x, exp.v2.x);
		check_hex("o_screen_tri.v2.y", o_screen_tri.v2.y, exp.v2.y);
	endtask

	task automatic check_edges(input gfx_fixed_pkg::edge_init_t exp);
		check_hex("o_edge_init.e0", o_edge_init.e0, exp.e0);
		check_hex("o_edge_init.e1", o_edge_init.e1, exp.e1);
		check_hex("o_edge_init.e2", o_edge_init.e2, exp.e2);
	endtask

	// one clock at the given raster position, then back to the parking spot
	task automatic pulse_raster(input int x, input int y);
		i_x = raster_timing_pkg::coord_t'(x);
		i_y = raster_timing_pkg::coord_t'(y);
		@(negedge clk);
		i_x = IDLE_X;
		i_y = IDLE_Y;
	endtask

	task automatic frame_setup();
		pulse_raster(1, V_ACTIVE);
		repeat (4) @(negedge clk);  // all three edges by then
	endtask

	task automatic load_tri(input gfx_fixed_pkg::world_tri_t t, input gfx_fixed_pkg::vp_matrix_t m,
			input bit extra_strobe);
		int cycles;
		i_tri = t;
		i_vp = m;
		i_tri_valid = 1'b1;
		@(negedge clk);
		i_tri_valid = 1'b0;
		check_hex("o_busy", o_busy, 1);
		if (extra_strobe) begin
			i_tri_valid = 1'b1;  // must be dropped while busy
			@(negedge clk);
			i_tri_valid = 1'b0;
		end
		cycles = 0;
		while (o_busy && cycles < BUSY_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		assert (!o_busy)
		else report_fail("o_busy stayed high past the timeout, the projection never finished");
	endtask

	task automatic test_reset();
		check_hex("o_busy", o_busy, 0);
		check_screen('0);
		check_edges('0);
	endtask

	task automatic test_single();
		gfx_fixed_pkg::world_tri_t t;
		gfx_fixed_pkg::vp_matrix_t m;
		t.v0 = make_vtx(16'h0080, 16'h0040, 0);
		t.v1 = make_vtx(-16'h00c0, 16'h0080, 16'h0020);
		t.v2 = make_vtx(16'h0040, -16'h0080, 0);
		m = '0;
		m.x.m0 = 16'sh0080;  // scale by 0.5
		m.y.m1 = 16'sh0080;
		m.w.m3 = gfx_fixed_pkg::Q_ONE;
		load_tri(t, m, 1'b0);
		check_screen('0);  // still the reset bank
		pulse_raster(0, V_ACTIVE);
		disp_model = project_tri(t, m);
		check_screen(disp_model);
	endtask

	task automatic test_swap();
		gfx_fixed_pkg::world_tri_t t;
		gfx_fixed_pkg::vp_matrix_t m;
		t.v0 = make_vtx(-16'h0100, -16'h0060, 0);
		t.v1 = make_vtx(16'h0120, 16'h0010, 0);
		t.v2 = make_vtx(16'h0030, 16'h00e0, 16'h0040);
		m = '0;
		m.x.m0 = 16'sh0080;
		m.x.m3 = 16'sh0020;  // shift right a bit
		m.y.m1 = 16'sh0080;
		m.y.m3 = -16'sh0010;
		m.w.m3 = gfx_fixed_pkg::Q_ONE;
		load_tri(t, m, 1'b1);
		repeat (3) begin
			@(negedge clk);
			check_hex("o_busy", o_busy, 0);
		end
		check_screen(disp_model);
		pulse_raster(0, V_ACTIVE);
		disp_model = project_tri(t, m);
		check_screen(disp_model);
	endtask

	task automatic test_frame_edges();
		frame_setup();
		edge_model = edges_of(disp_model);
		check_edges(edge_model);
	endtask

	task automatic test_line_step();
		gfx_fixed_pkg::edge_init_t exp;
		int b0;
		int b1;
		int b2;
		int n;
		b0 = int'(disp_model.v1.x) - int'(disp_model.v0.x);
		b1 = int'(disp_model.v2.x) - int'(disp_model.v1.x);
		b2 = int'(disp_model.v0.x) - int'(disp_model.v2.x);
		exp = edge_model;
		for (n = 1; n <= 5; n++) begin
			pulse_raster(H_ACTIVE, 16 * n);
			exp.e0 = gfx_fixed_pkg::int20_t'(int'(edge_model.e0) - n * b0);
			exp.e1 = gfx_fixed_pkg::int20_t'(int'(edge_model.e1) - n * b1);
			exp.e2 = gfx_fixed_pkg::int20_t'(int'(edge_model.e2) - n * b2);
			check_edges(exp);
		end
		// blanking rows, no step
		pulse_raster(H_ACTIVE, V_ACTIVE);
		pulse_raster(H_ACTIVE, V_ACTIVE + 7);
		check_edges(exp);
		edge_model = exp;
	endtask

	function automatic gfx_fixed_pkg::world_vtx_t rand_vtx();
		return make_vtx(int'($urandom % 2048) - 1024, int'($urandom % 2048) - 1024,
			int'($urandom % 256));  // x, y in [-4, 4), z in [0, 1)
	endfunction

	// w at least 8.0 against |x*scale| below 6, so |ndc| stays under 0.75
	task automatic test_random();
		gfx_fixed_pkg::world_tri_t t;
		gfx_fixed_pkg::vp_matrix_t m;
		int i;
		for (i = 0; i < N_RANDOM; i++) begin
			t.v0 = rand_vtx();
			t.v1 = rand_vtx();
			t.v2 = rand_vtx();
			m = '0;
			m.x.m0 = gfx_fixed_pkg::q8_8_t'(16'h0080 + $urandom % 256);
			m.y.m1 = gfx_fixed_pkg::q8_8_t'(16'h0080 + $urandom % 256);
			m.w.m2 = gfx_fixed_pkg::q8_8_t'($urandom % 256);
			m.w.m3 = 16'sh0800;
			load_tri(t, m, 1'b0);
			pulse_raster(0, V_ACTIVE);
			disp_model = project_tri(t, m);
			check_screen(disp_model);
			frame_setup();
			edge_model = edges_of(disp_model);
			check_edges(edge_model);
		end
	endtask

`endif

//--- testbench/tb_vertex_shader.sv
// raster position is driven by hand to the event points, no free-running display counter
`timescale 1ns/1ps

module tb_vertex_shader;

	localparam int H_ACTIVE = raster_timing_pkg::DEF_H_ACTIVE;
	localparam int V_ACTIVE = raster_timing_pkg::DEF_V_ACTIVE;
	localparam int BUSY_LIMIT = 1000;  // cycles, a projection needs about 260
	localparam int N_RANDOM = 20;
	// parked in vertical blank, away from every event
	localparam raster_timing_pkg::coord_t IDLE_X = 10'd5;
	localparam raster_timing_pkg::coord_t IDLE_Y = raster_timing_pkg::coord_t'(V_ACTIVE + 5);

	logic clk;
	logic reset;
	raster_timing_pkg::coord_t i_x;
	raster_timing_pkg::coord_t i_y;
	logic i_tri_valid;
	gfx_fixed_pkg::world_tri_t i_tri;
	gfx_fixed_pkg::vp_matrix_t i_vp;
	logic o_busy;
	gfx_fixed_pkg::screen_tri_t o_screen_tri;
	gfx_fixed_pkg::edge_init_t o_edge_init;

	gfx_fixed_pkg::screen_tri_t disp_model;  // expected displayed triangle
	gfx_fixed_pkg::edge_init_t edge_model;   // expected edge values

	vertex_shader_top #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)) DUT (
		.clk          (clk),
		.reset        (reset),
		.i_x          (i_x),
		.i_y          (i_y),
		.i_tri_valid  (i_tri_valid),
		.i_tri        (i_tri),
		.i_vp         (i_vp),
		.o_busy       (o_busy),
		.o_screen_tri (o_screen_tri),
		.o_edge_init  (o_edge_init)
	);

	always #5 clk = ~clk;

	task automatic report_fail(input string what);
		$display("%s", what);
		$display("=== FAIL ===");
		$fatal(1, "run stopped at the first error");
	endtask

	//////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////
	function automatic gfx_fixed_pkg::world_vtx_t make_vtx(int x, int y, int z);
		gfx_fixed_pkg::world_vtx_t v;
		v.x = gfx_fixed_pkg::q8_8_t'(x);
		v.y = gfx_fixed_pkg::q8_8_t'(y);
		v.z = gfx_fixed_pkg::q8_8_t'(z);
		return v;
	endfunction

	// full 32-bit sum, then back to Q8.8
	function automatic gfx_fixed_pkg::q8_8_t row_dot(gfx_fixed_pkg::world_vtx_t v,
			gfx_fixed_pkg::mat_row_t r);
		int sum;
		sum = int'(v.x) * int'(r.m0) + int'(v.y) * int'(r.m1) + int'(v.z) * int'(r.m2)
			+ int'(gfx_fixed_pkg::Q_ONE) * int'(r.m3);
		return gfx_fixed_pkg::q8_8_t'(sum >>> 8);
	endfunction

	function automatic gfx_fixed_pkg::q2_14_t ndc_of(gfx_fixed_pkg::q8_8_t c,
			gfx_fixed_pkg::q8_8_t w);
		int num;
		num = int'(c) <<< gfx_fixed_pkg::NDC_FRAC;
		if (w == 0)
			return '0;  // zero w maps to the centre
		return gfx_fixed_pkg::q2_14_t'(num / int'(w));  // truncates toward zero
	endfunction

	function automatic gfx_fixed_pkg::int20_t to_screen(gfx_fixed_pkg::q2_14_t n, int half);
		int prod;
		prod = int'(n) * half;
		return gfx_fixed_pkg::int20_t'(half + (prod >>> gfx_fixed_pkg::NDC_FRAC));
	endfunction

	function automatic gfx_fixed_pkg::screen_vtx_t project_vtx(gfx_fixed_pkg::world_vtx_t v,
			gfx_fixed_pkg::vp_matrix_t m);
		gfx_fixed_pkg::q8_8_t w;
		gfx_fixed_pkg::screen_vtx_t s;
		w = row_dot(v, m.w);
		s.x = to_screen(ndc_of(row_dot(v, m.x), w), H_ACTIVE / 2);
		s.y = to_screen(ndc_of(row_dot(v, m.y), w), V_ACTIVE / 2);  // y not flipped
		return s;
	endfunction

	function automatic gfx_fixed_pkg::screen_tri_t project_tri(gfx_fixed_pkg::world_tri_t t,
			gfx_fixed_pkg::vp_matrix_t m);
		gfx_fixed_pkg::screen_tri_t s;
		s.v0 = project_vtx(t.v0, m);
		s.v1 = project_vtx(t.v1, m);
		s.v2 = project_vtx(t.v2, m);
		return s;
	endfunction

	// x_a*(y_a - y_b) + y_a*(x_b - x_a), low 20 bits
	function automatic gfx_fixed_pkg::int20_t edge_value(gfx_fixed_pkg::screen_vtx_t a,
			gfx_fixed_pkg::screen_vtx_t b);
		int r;
		r = int'(a.x) * (int'(a.y) - int'(b.y)) + int'(a.y) * (int'(b.x) - int'(a.x));
		return gfx_fixed_pkg::int20_t'(r);
	endfunction

	function automatic gfx_fixed_pkg::edge_init_t edges_of(gfx_fixed_pkg::screen_tri_t s);
		gfx_fixed_pkg::edge_init_t e;
		e.e0 = edge_value(s.v0, s.v1);
		e.e1 = edge_value(s.v1, s.v2);
		e.e2 = edge_value(s.v2, s.v0);
		return e;
	endfunction

	`include "tb_tasks.svh"

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		i_x = IDLE_X;
		i_y = IDLE_Y;
		i_tri_valid = 1'b0;
		i_tri = '0;
		i_vp = '0;
		disp_model = '0;
		edge_model = '0;
		void'($urandom(32'h3502_1fb7));
		repeat (3) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		test_reset();
		test_single();
		test_swap();
		test_frame_edges();
		test_line_step();
		test_random();
		$display("=== PASS ===");
		$finish;
	end

endmodule

//--- flist.f
+incdir+testbench
verilog/gfx_fixed_pkg.sv
verilog/raster_timing_pkg.sv
verilog/persp_divide.sv
verilog/clip_transform.sv
verilog/screen_buffer.sv
verilog/edge_setup.sv
verilog/vertex_shader_top.sv
testbench/tb_vertex_shader.sv
